//--- hw/aes_types_pkg.sv
package aes_types_pkg;

	// One state byte
	typedef logic [7:0] byte_t;

	// Command word, also one state column
	typedef logic [31:0] word_t;

	// Data block, byte 0 in the top bits
	typedef logic [127:0] block_t;

	typedef logic [127:0] key_t;        // AES-128 cipher key

	typedef logic [3:0] round_t;        // Round counter 0..10

	// Command codes as written by the host
	localparam word_t cmd_ecb_encrypt = 32'h0000_0001;
	localparam word_t cmd_cbc_encrypt = 32'h0000_0003;

	localparam round_t num_rounds = 4'd10;  // AES-128

endpackage

//--- hw/aes_tables_pkg.sv
package aes_tables_pkg;
	import aes_types_pkg::*;

	// Forward S-box, entry 0x00 in the top byte
	localparam logic [2047:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic byte_t sbox(byte_t b);
		return sbox_table[2047 - 8 * int'(b) -: 8];
	endfunction

	// Multiply by x modulo the AES polynomial
	function automatic byte_t xtime(byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic byte_t rcon(round_t r);
		case (r)
			4'd1: return 8'h01;
			4'd2: return 8'h02;
			4'd3: return 8'h04;
			4'd4: return 8'h08;
			4'd5: return 8'h10;
			4'd6: return 8'h20;
			4'd7: return 8'h40;
			4'd8: return 8'h80;
			4'd9: return 8'h1b;
			4'd10: return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

	// Host buffer order is little endian inside each 32-bit word
	function automatic block_t swap_words(block_t b);
		block_t r;
		for (int i = 0; i < 16; i++) begin
			r[127 - 8 * i -: 8] = b[127 - 8 * ((i & ~3) + 3 - (i & 3)) -: 8];
		end
		return r;
	endfunction

endpackage

//--- hw/aes_cipher_if.sv
`timescale 1ns/10ps

interface aes_cipher_if import aes_types_pkg::*; ();
	logic   key_load;   // Key valid with this pulse
	logic   start;
	key_t   key;
	block_t in_blk;
	block_t out_blk;    // Valid while done
	logic   done;
	logic   busy;

	modport controller (
		output key_load, start, key, in_blk,
		input  out_blk, done, busy
	);

	modport core (
		input  key_load, start, key, in_blk,
		output out_blk, done, busy
	);

endinterface

//--- hw/aes_key_schedule.sv
`timescale 1ns/10ps

module aes_key_schedule import aes_types_pkg::*, aes_tables_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   key_load,
	input  logic   start,
	input  logic   advance,
	input  key_t   key,
	input  round_t round,
	output key_t   round_key
);

	key_t  key_reg;
	key_t  work_key;    // Key of the previous round
	key_t  next_key;
	word_t w0, w1, w2, w3;
	word_t rot_word;
	word_t sub_word;
	word_t n0, n1, n2, n3;

	assign {w0, w1, w2, w3} = work_key;
	assign rot_word = {w3[23:0], w3[31:24]};
	assign sub_word = {sbox(rot_word[31:24]), sbox(rot_word[23:16]),
		sbox(rot_word[15:8]), sbox(rot_word[7:0])};

	assign n0 = w0 ^ sub_word ^ {rcon(round), 24'h000000};
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;
	assign next_key = {n0, n1, n2, n3};

	// Round 0 uses the cipher key itself
	assign round_key = start ? key_reg : next_key;

	always_ff @(posedge clk) begin
		if (reset) begin
			key_reg <= '0;
			work_key <= '0;
		end else begin
			if (key_load)
				key_reg <= key;
			if (start)
				work_key <= key_reg;
			else if (advance)
				work_key <= next_key;
		end
	end

endmodule

//--- hw/aes_round_unit.sv
`timescale 1ns/10ps

module aes_round_unit import aes_types_pkg::*, aes_tables_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  logic   advance,
	input  logic   last,
	input  block_t in_blk,
	input  key_t   round_key,
	output block_t state
);

	block_t sub_blk;
	block_t shift_blk;
	block_t mix_blk;
	block_t next_state;

	// Byte (row, col) sits at index 4 * col + row
	function automatic block_t shift_rows(block_t s);
		block_t r;
		for (int c = 0; c < 4; c++) begin
			for (int row = 0; row < 4; row++) begin
				r[127 - 8 * (4 * c + row) -: 8] = s[127 - 8 * (4 * ((c + row) % 4) + row) -: 8];
			end
		end
		return r;
	endfunction

	function automatic word_t mix_column(word_t col);
		byte_t a0, a1, a2, a3;
		byte_t b0, b1, b2, b3;
		{a0, a1, a2, a3} = col;
		b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;    // 2 3 1 1
		b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
		b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
		b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		return {b0, b1, b2, b3};
	endfunction

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			sub_blk[127 - 8 * i -: 8] = sbox(state[127 - 8 * i -: 8]);
		end
	end

	assign shift_blk = shift_rows(sub_blk);

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			mix_blk[127 - 32 * c -: 32] = mix_column(shift_blk[127 - 32 * c -: 32]);
		end
	end

	// Final round has no MixColumns
	assign next_state = (last ? shift_blk : mix_blk) ^ round_key;

	always_ff @(posedge clk) begin
		if (reset)
			state <= '0;
		else if (start)
			state <= in_blk ^ round_key;    // Initial AddRoundKey
		else if (advance)
			state <= next_state;
	end

endmodule

//--- hw/aes_cipher_core.sv
`timescale 1ns/10ps

module aes_cipher_core import aes_types_pkg::*; (
	input logic         clk,
	input logic         reset,
	aes_cipher_if.core  cif
);

	round_t rnd;        // Round being applied
	logic   advance;
	logic   last;
	key_t   round_key;
	block_t state;

	assign advance = cif.busy && !cif.done;
	assign last = (rnd == num_rounds);
	assign cif.out_blk = state;

	aes_key_schedule u_key_schedule (
		.clk       (clk),
		.reset     (reset),
		.key_load  (cif.key_load),
		.start     (cif.start),
		.advance   (advance),
		.key       (cif.key),
		.round     (rnd),
		.round_key (round_key)
	);

	aes_round_unit u_round_unit (
		.clk       (clk),
		.reset     (reset),
		.start     (cif.start),
		.advance   (advance),
		.last      (last),
		.in_blk    (cif.in_blk),
		.round_key (round_key),
		.state     (state)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			rnd <= '0;
			cif.busy <= 1'b0;
			cif.done <= 1'b0;
		end else begin
			cif.done <= advance && last;
			if (cif.start) begin
				rnd <= 4'd1;
				cif.busy <= 1'b1;
			end else begin
				if (advance && !last)
					rnd <= round_t'(rnd + 1'b1);
				if (cif.done)
					cif.busy <= 1'b0;   // Busy covers the done cycle
			end
		end
	end

endmodule

//--- hw/aes_mode_controller.sv
`timescale 1ns/10ps

module aes_mode_controller import aes_types_pkg::*, aes_tables_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  word_t             cmd,
	input  block_t            in_data,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic              input_done,
	output block_t            out_data,
	output logic              out_valid,
	input  logic              out_ready,
	output logic              processing_done,
	aes_cipher_if.controller  cif
);

	typedef enum logic [2:0] {
		get_key,
		get_iv,
		start_block,
		wait_core,
		store_block
	} ctrl_state_t;

	ctrl_state_t state;
	word_t       mode;      // Command of the block in flight
	block_t      iv;        // Chaining value for CBC
	block_t      blk_reg;
	block_t      in_swapped;
	logic        accept;
	logic        launch;    // Delays start by one edge

	function automatic logic chained(word_t c);
		case (c)
			cmd_cbc_encrypt: return 1'b1;
			cmd_ecb_encrypt: return 1'b0;
			default: return 1'b0;
		endcase
	endfunction

	assign accept = in_valid && in_ready;
	assign in_swapped = swap_words(in_data);

	assign cif.key = in_swapped;
	assign cif.key_load = accept && (state == get_key);
	assign cif.in_blk = blk_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= get_key;
			mode <= '0;
			in_ready <= 1'b0;
			out_valid <= 1'b0;
			processing_done <= 1'b0;
			launch <= 1'b0;
			cif.start <= 1'b0;
		end else begin
			processing_done <= 1'b0;
			launch <= 1'b0;
			cif.start <= launch;

			case (state)
				get_key: begin
					in_ready <= 1'b1;
					if (accept) begin
						in_ready <= 1'b0;
						mode <= cmd;
						state <= chained(cmd) ? get_iv : start_block;
					end
				end
				get_iv: begin
					in_ready <= 1'b1;
					if (accept) begin
						in_ready <= 1'b0;
						iv <= in_swapped;
						state <= start_block;
					end
				end
				start_block: begin
					in_ready <= !cif.busy;
					if (accept) begin
						in_ready <= 1'b0;
						mode <= cmd;
						blk_reg <= chained(cmd) ? (in_swapped ^ iv) : in_swapped;
						launch <= 1'b1;
						state <= wait_core;
					end else if (input_done && !in_valid) begin
						// Message over, next word is a key
						in_ready <= 1'b0;
						processing_done <= 1'b1;
						state <= get_key;
					end
				end
				wait_core: begin
					if (cif.done) begin
						out_valid <= 1'b1;
						out_data <= swap_words(cif.out_blk);
						if (chained(mode))
							iv <= cif.out_blk;
						state <= store_block;
					end
				end
				store_block: begin
					if (out_ready) begin    // Held until taken
						out_valid <= 1'b0;
						state <= start_block;
					end
				end
				default: state <= get_key;
			endcase
		end
	end

endmodule

//--- hw/aes_stream_top.sv
`timescale 1ns/10ps

module aes_stream_top import aes_types_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  word_t  cmd,
	input  block_t in_data,
	input  logic   in_valid,
	output logic   in_ready,
	input  logic   input_done,
	output block_t out_data,
	output logic   out_valid,
	input  logic   out_ready,
	output logic   processing_done
);

	aes_cipher_if cif ();

	aes_mode_controller u_ctrl (
		.clk             (clk),
		.reset           (reset),
		.cmd             (cmd),
		.in_data         (in_data),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.input_done      (input_done),
		.out_data        (out_data),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.processing_done (processing_done),
		.cif             (cif.controller)
	);

	aes_cipher_core u_core (
		.clk   (clk),
		.reset (reset),
		.cif   (cif.core)
	);

endmodule

//--- test/aes_stream_properties.sv
`timescale 1ns/10ps

module aes_stream_properties import aes_types_pkg::*; (
	input logic   clk,
	input logic   reset,
	input logic   in_ready,
	input logic   out_valid,
	input logic   out_ready,
	input block_t out_data,
	input logic   processing_done
);

	// One block in flight, so input and output never open together
	assert property (@(posedge clk) disable iff (reset) !(out_valid && in_ready))
		else $error("in_ready and out_valid high in the same cycle");

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("Output changed while waiting for out_ready");

	assert property (@(posedge clk) reset |=> !in_ready && !out_valid && !processing_done)
		else $error("Control output high during reset");

	assert property (@(posedge clk) disable iff (reset) processing_done |=> !processing_done)
		else $error("processing_done longer than one cycle");

endmodule

bind aes_stream_top aes_stream_properties u_props (
	.clk             (clk),
	.reset           (reset),
	.in_ready        (in_ready),
	.out_valid       (out_valid),
	.out_ready       (out_ready),
	.out_data        (out_data),
	.processing_done (processing_done)
);

//--- test/aes_stream_tb.sv
`timescale 1ns/10ps

module aes_stream_tb import aes_types_pkg::*; ();

	logic   clk = 1'b0;
	logic   reset;
	word_t  cmd;
	block_t in_data;
	logic   in_valid;
	logic   in_ready;
	logic   input_done;
	block_t out_data;
	logic   out_valid;
	logic   out_ready;
	logic   processing_done;

	block_t      vec_mem [0:255];
	block_t      exp_q [$];         // Expected ciphertexts in order
	int unsigned rng_state = 48086;
	int          cycle = 0;
	int          timeout_cycles = 0;
	int          accept_edge;
	int          first_accept;
	logic        first_pending = 1'b0;
	logic        hold_ready = 1'b1;
	logic        prev_valid = 1'b0;
	int          out_total = 0;
	int          done_total = 0;

	aes_stream_top u_dut (
		.clk             (clk),
		.reset           (reset),
		.cmd             (cmd),
		.in_data         (in_data),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.input_done      (input_done),
		.out_data        (out_data),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.processing_done (processing_done)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;     // Edges seen so far

	function automatic int unsigned next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_word(input block_t w, input int gap);
		repeat (gap) @(negedge clk);
		in_data = w;
		in_valid = 1'b1;
		while (!in_ready)
			@(negedge clk);
		accept_edge = cycle + 1;    // Taken on the coming edge
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Output side, all sampled between edges
	always @(negedge clk) begin
		if (!reset) begin
			out_ready = hold_ready || (next_random() % 4 != 0);   // Random stalls
			if (out_valid && !prev_valid && first_pending) begin
				first_pending = 1'b0;
				assert (cycle - first_accept == 13) else
					stop_with_failure($sformatf(
						"error at %0t: first out_valid latency got %0d expected 13",
						$time, cycle - first_accept));
			end
			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0) else
					stop_with_failure("An output block appeared with no block pending");
				assert (out_data === exp_q[0]) else
					stop_with_failure($sformatf("error at %0t: out_data got %h expected %h",
						$time, out_data, exp_q[0]));
				void'(exp_q.pop_front());
				out_total++;
				hold_ready = 1'b0;
			end
			if (processing_done)
				done_total++;
			prev_valid = out_valid;
		end
	end

	initial begin
		int    p;
		int    nblk;
		int    msg_total;
		int    blk_total;
		word_t mode;

		reset = 1'b1;
		cmd = '0;
		in_data = '0;
		in_valid = 1'b0;
		input_done = 1'b0;
		out_ready = 1'b0;
		$readmemh("test/aes_stream_vectors.txt", vec_mem);

		p = 0;
		msg_total = 0;
		blk_total = 0;
		while (vec_mem[p][31:0] == cmd_ecb_encrypt || vec_mem[p][31:0] == cmd_cbc_encrypt) begin
			nblk = int'(vec_mem[p + 3]);
			msg_total++;
			blk_total += nblk;
			p += 4 + 2 * nblk;
		end
		assert (msg_total > 0) else
			stop_with_failure("No messages could be read from the vector file");
		timeout_cycles = 40 * blk_total + 100 * msg_total + 200;

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		p = 0;
		for (int m = 0; m < msg_total; m++) begin
			mode = word_t'(vec_mem[p]);
			nblk = int'(vec_mem[p + 3]);
			cmd = mode;
			hold_ready = 1'b1;
			send_word(vec_mem[p + 1], 0);
			if (mode == cmd_cbc_encrypt)
				send_word(vec_mem[p + 2], next_random() % 3);
			for (int b = 0; b < nblk; b++) begin
				exp_q.push_back(vec_mem[p + 5 + 2 * b]);
				send_word(vec_mem[p + 4 + 2 * b], next_random() % 3);
				if (b == 0) begin
					first_accept = accept_edge;
					first_pending = 1'b1;
				end
			end
			while (exp_q.size() != 0)
				@(negedge clk);
			input_done = 1'b1;  // No word offered now
			while (!processing_done)
				@(negedge clk);
			input_done = 1'b0;
			p += 4 + 2 * nblk;
		end

		@(negedge clk);
		if (out_total == blk_total && done_total == msg_total) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf("Counts wrong: %0d of %0d outputs, %0d of %0d done pulses",
				out_total, blk_total, done_total, msg_total));
		end
	end

	// Watchdog
	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		stop_with_failure("Timeout while waiting for the DUT");
	end

endmodule

//--- test/aes_stream_vectors.txt
// Message header: mode key iv blocks, then one line per block: plaintext ciphertext
// Stream byte order throughout; mode 1 is ECB, 3 is CBC, 0 ends the list
1 03020100070605040b0a09080f0e0d0c 00000000000000000000000000000000 1
3322110077665544bbaa9988ffeeddcc d8e0c46930047b6a80b7cdd85ac5b470
3 16157e2ba6d2ae288815f7ab3c4fcf09 03020100070605040b0a09080f0e0d0c 4
e2bec16b969f402e117e3de92a179373 acab497646b219819b8ee9ce7d19e912
578a2dae9cac031eac6fb79e518eaf45 9bcb8650ee1972503a11db95b2787691
461cc83011e45ca319c1fbe5ef520a1a b8d6be733b74c1e39ee6167116952222
45249ff6179b4fdf7b412bad10376ce6 a1caf13f09ac1f6830ca0e12a7e18675
1 16157e2ba6d2ae288815f7ab3c4fcf09 00000000000000000000000000000000 5
a8f643328d305a88a2983131340737e0 1d842539fb09dc02978511dc320b6a19
e2bec16b969f402e117e3de92a179373 b47bd73a60367a0df3ca9ea897ef6624
578a2dae9cac031eac6fb79e518eaf45 85d5d3f59d69b9035a8985e7afbafd96
461cc83011e45ca319c1fbe5ef520a1a 7fcdb14323ce8e59e3001b88880603ed
45249ff6179b4fdf7b412bad10376ce6 5e780c7b3fade82771202382d45d7204
0

//--- aes_stream_top.f
hw/aes_types_pkg.sv
hw/aes_tables_pkg.sv
hw/aes_cipher_if.sv
hw/aes_key_schedule.sv
hw/aes_round_unit.sv
hw/aes_cipher_core.sv
hw/aes_mode_controller.sv
hw/aes_stream_top.sv
test/aes_stream_properties.sv
test/aes_stream_tb.sv

//--- Bender.yml
package:
  name: aes_stream

sources:
  - files:
      - hw/aes_types_pkg.sv
      - hw/aes_tables_pkg.sv
      - hw/aes_cipher_if.sv
      - hw/aes_key_schedule.sv
      - hw/aes_round_unit.sv
      - hw/aes_cipher_core.sv
      - hw/aes_mode_controller.sv
      - hw/aes_stream_top.sv
  - target: test
    files:
      - test/aes_stream_properties.sv
      - test/aes_stream_tb.sv
